/* filelist.f */
+incdir+rtl
rtl/rf_pkg.sv
rtl/rf_config_bank.sv
rtl/rf_status_read.sv
rtl/rf_direct.sv
verif/tb_clock_gen.sv
verif/tb_rf_direct.sv

/* rtl/rf_config_bank.sv */
`timescale 1ns/10ps
`include "rf_params.svh"

module rf_config_bank
(
        input  logic                            i_clock,
        input  logic                            i_reset,
        input  logic                            i_cmd_enable,
        input  rf_pkg::opcode_t                 i_cmd_opcode,
        input  rf_pkg::cmd_data_t               i_cmd_data,

        output logic                            o_soft_reset,
        output logic                            o_loopback,
        output logic                            o_tx_test_pattern,
        output logic                            o_rx_test_pattern,
        output rf_pkg::pcs_enable_t             o_enable_modules,

        output rf_pkg::threshold_t              o_blksync_invalid_sh_limit,
        output rf_pkg::threshold_t              o_blksync_locked_window,
        output rf_pkg::threshold_t              o_blksync_unlocked_window,
        output rf_pkg::threshold_t              o_align_invalid_thr,
        output rf_pkg::threshold_t              o_align_valid_thr,
        output rf_pkg::align_mask_t             o_align_mask,

        output rf_pkg::lane_vec_t               o_channel_select,
        output rf_pkg::lane_vec_t               o_channel_start_break,
        output logic [`RF_N_CHNL_MODULES-1:0]   o_channel_update,
        output logic [`RF_NB_CHNL_MODE-1:0]     o_channel_mode,
        output logic [`RF_NB_CHNL_BURST-1:0]    o_channel_burst,
        output logic [`RF_NB_CHNL_PERIOD-1:0]   o_channel_period,
        output logic [`RF_NB_CHNL_REPEAT-1:0]   o_channel_repeat,
        output logic [`RF_NB_CHNL_SKEW-1:0]     o_channel_skew
);

localparam NB_MEM_FLAT = (`RF_N_CONFIG_REGS - 1) * `RF_NB_CMD_DATA;

rf_pkg::cmd_data_t      config_mem [1:`RF_N_CONFIG_REGS-1];
logic                   wr_valid;
logic [NB_MEM_FLAT-1:0] mem_flat;
logic [NB_MEM_FLAT-1:0] wr_slot_bits;
logic [3*`RF_NB_CMD_DATA-1:0] mask_full;

// only 1..19 are writable slots
assign wr_valid = i_cmd_enable &&
                  (i_cmd_opcode >= `RF_OP_PCS_CONTROL) &&
                  (i_cmd_opcode <= `RF_OP_CHNL_SKEW);

always_ff @(posedge i_clock)
begin
        if (i_reset)
        begin
                for (int k = 1; k < `RF_N_CONFIG_REGS; k++)
                        config_mem[k] <= '0;
        end
        else if (wr_valid)
                config_mem[i_cmd_opcode] <= i_cmd_data;   // level enable, rewrites every cycle
end

// control bits share slot 1
assign o_soft_reset      = config_mem[`RF_OP_PCS_CONTROL][0];
assign o_loopback        = config_mem[`RF_OP_PCS_CONTROL][1];
assign o_tx_test_pattern = config_mem[`RF_OP_PCS_CONTROL][2];
assign o_rx_test_pattern = config_mem[`RF_OP_PCS_CONTROL][3];

assign o_enable_modules = rf_pkg::pcs_enable_t'(config_mem[`RF_OP_PCS_ENABLE_MODULES]);

assign o_blksync_invalid_sh_limit =
        rf_pkg::threshold_t'(config_mem[`RF_OP_BLKSYNC_INVALID_SH]);
assign o_blksync_locked_window =
        rf_pkg::threshold_t'(config_mem[`RF_OP_BLKSYNC_LOCKED_WIN]);
assign o_blksync_unlocked_window =
        rf_pkg::threshold_t'(config_mem[`RF_OP_BLKSYNC_UNLOCKED_WIN]);
assign o_align_invalid_thr = rf_pkg::threshold_t'(config_mem[`RF_OP_ALIGN_INVALID_THR]);
assign o_align_valid_thr   = rf_pkg::threshold_t'(config_mem[`RF_OP_ALIGN_VALID_THR]);

// mask built from three writes, top 6 bits of high word dropped
assign mask_full = {config_mem[`RF_OP_ALIGN_MASK_HIGH],
                    config_mem[`RF_OP_ALIGN_MASK_MID],
                    config_mem[`RF_OP_ALIGN_MASK_LOW]};
assign o_align_mask = mask_full[`RF_NB_MASK-1:0];

assign o_channel_select      = rf_pkg::lane_vec_t'(config_mem[`RF_OP_CHNL_LANE_SEL]);
assign o_channel_start_break = rf_pkg::lane_vec_t'(config_mem[`RF_OP_CHNL_START_SEQ]);
assign o_channel_update      = config_mem[`RF_OP_CHNL_UPDATE][`RF_N_CHNL_MODULES-1:0];
assign o_channel_mode        = config_mem[`RF_OP_CHNL_MODE][`RF_NB_CHNL_MODE-1:0];
assign o_channel_burst       = config_mem[`RF_OP_CHNL_BURST][`RF_NB_CHNL_BURST-1:0];
assign o_channel_period      = config_mem[`RF_OP_CHNL_PERIOD][`RF_NB_CHNL_PERIOD-1:0];
assign o_channel_repeat      = config_mem[`RF_OP_CHNL_REPEAT][`RF_NB_CHNL_REPEAT-1:0];
assign o_channel_skew        = config_mem[`RF_OP_CHNL_SKEW][`RF_NB_CHNL_SKEW-1:0];

// flat view of all slots, for the hold check
always_comb
begin
        for (int k = 1; k < `RF_N_CONFIG_REGS; k++)
                mem_flat[(k-1)*`RF_NB_CMD_DATA +: `RF_NB_CMD_DATA] = config_mem[k];
end

// bits of the one slot a write may touch
always_comb
begin
        wr_slot_bits = '0;
        if (wr_valid)
                wr_slot_bits[(i_cmd_opcode-1)*`RF_NB_CMD_DATA +: `RF_NB_CMD_DATA] = '1;
end

// storage only moves in the slot of a decoded write
a_mem_hold: assert property (
        @(posedge i_clock) disable iff (i_reset)
        ((mem_flat ^ $past(mem_flat)) & ~$past(wr_slot_bits)) == '0
);

endmodule

/* rtl/rf_direct.sv */
`timescale 1ns/10ps
`include "rf_params.svh"

module rf_direct
(
        input  logic                            i_clock,
        input  logic                            i_reset,
        input  rf_pkg::gpio_word_t              i_gpio,

        input  rf_pkg::lane_vec_t               i_pcs_block_lock,
        input  rf_pkg::lane_vec_t               i_pcs_lane_aligned,
        input  logic                            i_pcs_all_deskew,
        input  logic                            i_pcs_all_reorder,
        input  rf_pkg::lane_vec_t               i_pcs_hi_ber,
        input  rf_pkg::ber_bus_t                i_pcs_ber_counter,
        input  logic [`RF_NB_BER_COMMON-1:0]    i_pcs_ber_common,
        input  rf_pkg::gpio_word_t              i_pcs_decoder_err,
        input  logic [15:0]                     i_pcs_pattern_err,
        input  rf_pkg::lane_id_bus_t            i_pcs_lane_ids,

        output rf_pkg::gpio_word_t              o_gpio,
        output logic                            o_soft_reset,
        output logic                            o_loopback,
        output logic                            o_tx_test_pattern,
        output logic                            o_rx_test_pattern,
        output rf_pkg::pcs_enable_t             o_enable_modules,

        output rf_pkg::threshold_t              o_blksync_invalid_sh_limit,
        output rf_pkg::threshold_t              o_blksync_locked_window,
        output rf_pkg::threshold_t              o_blksync_unlocked_window,
        output rf_pkg::threshold_t              o_align_invalid_thr,
        output rf_pkg::threshold_t              o_align_valid_thr,
        output rf_pkg::align_mask_t             o_align_mask,

        output rf_pkg::lane_vec_t               o_channel_select,      // one per lane
        output logic [`RF_N_CHNL_MODULES-1:0]   o_channel_update,
        output rf_pkg::lane_vec_t               o_channel_start_break, // one per lane
        output logic [`RF_NB_CHNL_MODE-1:0]     o_channel_mode,
        output logic [`RF_NB_CHNL_BURST-1:0]    o_channel_burst,
        output logic [`RF_NB_CHNL_PERIOD-1:0]   o_channel_period,
        output logic [`RF_NB_CHNL_REPEAT-1:0]   o_channel_repeat,
        output logic [`RF_NB_CHNL_SKEW-1:0]     o_channel_skew
);

rf_pkg::opcode_t        cmd_opcode;
logic                   cmd_enable;
rf_pkg::cmd_data_t      cmd_data;

// opcode on top, enable just above the data field
assign cmd_opcode = i_gpio[`RF_NB_GPIO-1 -: `RF_NB_OPCODE];
assign cmd_enable = i_gpio[`RF_NB_CMD_DATA];
assign cmd_data   = i_gpio[`RF_NB_CMD_DATA-1:0];

rf_config_bank u_config_bank
(
        .i_clock                        (i_clock),
        .i_reset                        (i_reset),
        .i_cmd_enable                   (cmd_enable),
        .i_cmd_opcode                   (cmd_opcode),
        .i_cmd_data                     (cmd_data),
        .o_soft_reset                   (o_soft_reset),
        .o_loopback                     (o_loopback),
        .o_tx_test_pattern              (o_tx_test_pattern),
        .o_rx_test_pattern              (o_rx_test_pattern),
        .o_enable_modules               (o_enable_modules),
        .o_blksync_invalid_sh_limit     (o_blksync_invalid_sh_limit),
        .o_blksync_locked_window        (o_blksync_locked_window),
        .o_blksync_unlocked_window      (o_blksync_unlocked_window),
        .o_align_invalid_thr            (o_align_invalid_thr),
        .o_align_valid_thr              (o_align_valid_thr),
        .o_align_mask                   (o_align_mask),
        .o_channel_select               (o_channel_select),
        .o_channel_start_break          (o_channel_start_break),
        .o_channel_update               (o_channel_update),
        .o_channel_mode                 (o_channel_mode),
        .o_channel_burst                (o_channel_burst),
        .o_channel_period               (o_channel_period),
        .o_channel_repeat               (o_channel_repeat),
        .o_channel_skew                 (o_channel_skew)
);

rf_status_read u_status_read
(
        .i_clock                        (i_clock),
        .i_reset                        (i_reset),
        .i_cmd_enable                   (cmd_enable),
        .i_cmd_opcode                   (cmd_opcode),
        .i_pcs_block_lock               (i_pcs_block_lock),
        .i_pcs_lane_aligned             (i_pcs_lane_aligned),
        .i_pcs_hi_ber                   (i_pcs_hi_ber),
        .i_pcs_all_deskew               (i_pcs_all_deskew),
        .i_pcs_all_reorder              (i_pcs_all_reorder),
        .i_pcs_ber_counter              (i_pcs_ber_counter),
        .i_pcs_ber_common               (i_pcs_ber_common),
        .i_pcs_decoder_err              (i_pcs_decoder_err),
        .i_pcs_pattern_err              (i_pcs_pattern_err),
        .i_pcs_lane_ids                 (i_pcs_lane_ids),
        .o_gpio                         (o_gpio)
);

endmodule

/* rtl/rf_params.svh */
`ifndef RF_PARAMS_SVH
`define RF_PARAMS_SVH

// lane and module counts
`define RF_N_LANES              20
`define RF_N_PCS_MODULES        24
`define RF_N_CHNL_MODULES       4
`define RF_N_CONFIG_REGS        20      // slot 0 never written

// gpio word is {opcode, enable, data}
`define RF_NB_GPIO              32
`define RF_NB_OPCODE            7
`define RF_NB_CMD_DATA          24

// pcs status field widths
`define RF_NB_BER_CNT           20
`define RF_NB_BER_COMMON        27
`define RF_NB_LANE_ID           5
`define RF_NB_MASK              66

// channel config field widths
`define RF_NB_CHNL_MODE         4
`define RF_NB_CHNL_BURST        22
`define RF_NB_CHNL_PERIOD       22
`define RF_NB_CHNL_REPEAT       22
`define RF_NB_CHNL_SKEW         5

// write opcodes, also the slot index
`define RF_OP_PCS_CONTROL               1
`define RF_OP_PCS_ENABLE_MODULES        2
`define RF_OP_BLKSYNC_INVALID_SH        3
`define RF_OP_BLKSYNC_LOCKED_WIN        4
`define RF_OP_BLKSYNC_UNLOCKED_WIN      5
`define RF_OP_ALIGN_INVALID_THR         6
`define RF_OP_ALIGN_VALID_THR           7
`define RF_OP_ALIGN_MASK_LOW            8
`define RF_OP_ALIGN_MASK_MID            9
`define RF_OP_ALIGN_MASK_HIGH           10
`define RF_OP_CHNL_UPDATE               11
`define RF_OP_CHNL_START_SEQ            12
`define RF_OP_CHNL_BLOCK_SEL            13
`define RF_OP_CHNL_MODE                 14
`define RF_OP_CHNL_BURST                15
`define RF_OP_CHNL_PERIOD               16
`define RF_OP_CHNL_REPEAT               17
`define RF_OP_CHNL_LANE_SEL             18
`define RF_OP_CHNL_SKEW                 19

// read opcodes
`define RF_OP_STATUS                    40
`define RF_OP_HI_BER                    41
`define RF_OP_BLOCK_LOCK                42
`define RF_OP_ALIGN_LOCK                43
`define RF_OP_BERCNT_LANE0              44      // lane n at 44+n
`define RF_OP_BER_COMMON                64
`define RF_OP_ERR_BLOCKS                65
`define RF_OP_PATTERN_ERR               66
`define RF_OP_LANE_MAP_A                67      // word k at 67+k

`endif

/* rtl/rf_pkg.sv */
`include "rf_params.svh"

package rf_pkg;

        // gpio command fields
        typedef logic [`RF_NB_OPCODE-1:0]       opcode_t;
        typedef logic [`RF_NB_CMD_DATA-1:0]     cmd_data_t;
        typedef logic [`RF_NB_GPIO-1:0]         gpio_word_t;

        // one bit per lane
        typedef logic [`RF_N_LANES-1:0]         lane_vec_t;

        // block sync and alignment limits
        typedef logic [19:0]                    threshold_t;

        // lane 0 sits in the top slice of both buses
        typedef logic [`RF_NB_BER_CNT*`RF_N_LANES-1:0]  ber_bus_t;
        typedef logic [`RF_NB_LANE_ID*`RF_N_LANES-1:0]  lane_id_bus_t;

        typedef logic [`RF_NB_MASK-1:0]         align_mask_t;
        typedef logic [`RF_N_PCS_MODULES-1:0]   pcs_enable_t;

endpackage

/* rtl/rf_status_read.sv */
`timescale 1ns/10ps
`include "rf_params.svh"

module rf_status_read
(
        input  logic                            i_clock,
        input  logic                            i_reset,
        input  logic                            i_cmd_enable,
        input  rf_pkg::opcode_t                 i_cmd_opcode,

        input  rf_pkg::lane_vec_t               i_pcs_block_lock,
        input  rf_pkg::lane_vec_t               i_pcs_lane_aligned,
        input  rf_pkg::lane_vec_t               i_pcs_hi_ber,
        input  logic                            i_pcs_all_deskew,
        input  logic                            i_pcs_all_reorder,
        input  rf_pkg::ber_bus_t                i_pcs_ber_counter,
        input  logic [`RF_NB_BER_COMMON-1:0]    i_pcs_ber_common,
        input  rf_pkg::gpio_word_t              i_pcs_decoder_err,
        input  logic [15:0]                     i_pcs_pattern_err,
        input  rf_pkg::lane_id_bus_t            i_pcs_lane_ids,

        output rf_pkg::gpio_word_t              o_gpio
);

localparam LANES_PER_WORD = 4;
localparam NB_ID_BYTE     = 8;
localparam N_MAP_WORDS    = `RF_N_LANES / LANES_PER_WORD;

rf_pkg::gpio_word_t             gpio_q;
rf_pkg::gpio_word_t             gpio_next;
rf_pkg::gpio_word_t             lane_map_word;
rf_pkg::opcode_t                ber_lane;
rf_pkg::opcode_t                map_idx;
logic [`RF_NB_BER_CNT-1:0]      ber_lane_cnt;
logic [3:0]                     status_bits;

assign status_bits = {&i_pcs_block_lock, &i_pcs_lane_aligned,
                      i_pcs_all_deskew, i_pcs_all_reorder};

// lane and word index straight from the opcode
assign ber_lane = rf_pkg::opcode_t'(i_cmd_opcode - `RF_OP_BERCNT_LANE0);
assign map_idx  = rf_pkg::opcode_t'(i_cmd_opcode - `RF_OP_LANE_MAP_A);

assign ber_lane_cnt =
        i_pcs_ber_counter[`RF_NB_BER_CNT*(`RF_N_LANES - ber_lane) - 1 -: `RF_NB_BER_CNT];

// four ids per word, first lane in top byte
always_comb
begin
        lane_map_word = '0;
        for (int j = 0; j < LANES_PER_WORD; j++)
        begin
                lane_map_word[`RF_NB_GPIO - 1 - NB_ID_BYTE*j -: NB_ID_BYTE] =
                        NB_ID_BYTE'(i_pcs_lane_ids[`RF_NB_LANE_ID *
                        (`RF_N_LANES - LANES_PER_WORD*map_idx - j) - 1 -: `RF_NB_LANE_ID]);
        end
end

always_comb
begin
        gpio_next = gpio_q;     // writes and unknown opcodes keep last read
        case (i_cmd_opcode) inside
                `RF_OP_STATUS:
                        gpio_next = rf_pkg::gpio_word_t'(status_bits);
                `RF_OP_HI_BER:
                        gpio_next = rf_pkg::gpio_word_t'(i_pcs_hi_ber);
                `RF_OP_BLOCK_LOCK:
                        gpio_next = rf_pkg::gpio_word_t'(i_pcs_block_lock);
                `RF_OP_ALIGN_LOCK:
                        gpio_next = rf_pkg::gpio_word_t'(i_pcs_lane_aligned);
                [`RF_OP_BERCNT_LANE0 : `RF_OP_BERCNT_LANE0 + `RF_N_LANES - 1]:
                        gpio_next = rf_pkg::gpio_word_t'(ber_lane_cnt);
                `RF_OP_BER_COMMON:
                        gpio_next = rf_pkg::gpio_word_t'(i_pcs_ber_common);
                `RF_OP_ERR_BLOCKS:
                        gpio_next = i_pcs_decoder_err;
                `RF_OP_PATTERN_ERR:
                        gpio_next = rf_pkg::gpio_word_t'(i_pcs_pattern_err);
                [`RF_OP_LANE_MAP_A : `RF_OP_LANE_MAP_A + N_MAP_WORDS - 1]:
                        gpio_next = lane_map_word;
                default:
                        gpio_next = gpio_q;
        endcase
end

always_ff @(posedge i_clock)
begin
        if (i_reset)
                gpio_q <= '0;
        else if (i_cmd_enable)
                gpio_q <= gpio_next;
end

assign o_gpio = gpio_q;

// readback only moves on an enabled read opcode
a_gpio_hold: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(i_cmd_enable &&
          i_cmd_opcode inside {[`RF_OP_STATUS : `RF_OP_LANE_MAP_A + N_MAP_WORDS - 1]})
        |=> $stable(o_gpio)
);

endmodule

/* verif/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen
#(
        parameter HALF_PERIOD  = 50,
        parameter RESET_CYCLES = 8
)
(
        output logic    o_clock,
        output logic    o_reset
);

initial
begin
        o_clock = 1'b0;
        forever
                #HALF_PERIOD o_clock = ~o_clock;
end

// release lands 5 ns after an edge, like the other inputs
initial
begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clock);
        #5 o_reset = 1'b0;
end

endmodule

/* verif/tb_rf_direct.sv */
`timescale 1ns/10ps
`include "rf_params.svh"

module tb_rf_direct;

localparam N_WRITES    = 400;
localparam N_READS     = 300;
localparam N_MIXED     = 300;
localparam CYCLE_LIMIT = 8 + 1 + N_WRITES + 3 + N_READS + N_MIXED + 50;

logic                           clock;
logic                           reset;
rf_pkg::gpio_word_t             i_gpio;
rf_pkg::lane_vec_t              block_lock, lane_aligned, hi_ber;
logic                           all_deskew, all_reorder;
rf_pkg::ber_bus_t               ber_counter;
logic [`RF_NB_BER_COMMON-1:0]   ber_common;
rf_pkg::gpio_word_t             decoder_err;
logic [15:0]                    pattern_err;
rf_pkg::lane_id_bus_t           lane_ids;

rf_pkg::gpio_word_t             o_gpio;
logic                           o_soft_reset, o_loopback, o_tx_test_pattern, o_rx_test_pattern;
rf_pkg::pcs_enable_t            o_enable_modules;
rf_pkg::threshold_t             o_blksync_invalid_sh_limit, o_blksync_locked_window;
rf_pkg::threshold_t             o_blksync_unlocked_window, o_align_invalid_thr;
rf_pkg::threshold_t             o_align_valid_thr;
rf_pkg::align_mask_t            o_align_mask;
rf_pkg::lane_vec_t              o_channel_select, o_channel_start_break;
logic [3:0]                     o_channel_update, o_channel_mode;
logic [21:0]                    o_channel_burst, o_channel_period, o_channel_repeat;
logic [4:0]                     o_channel_skew;

logic [31:0]                    seed;
logic [23:0]                    cfg [1:19];     // model of the write slots
logic [31:0]                    exp_gpio;
int                             err_cfg;
int                             err_gpio;
int                             cycles;

tb_clock_gen clock_gen (.o_clock(clock), .o_reset(reset));

rf_direct UUT
(
        .i_clock(clock), .i_reset(reset), .i_gpio(i_gpio),
        .i_pcs_block_lock(block_lock), .i_pcs_lane_aligned(lane_aligned),
        .i_pcs_all_deskew(all_deskew), .i_pcs_all_reorder(all_reorder),
        .i_pcs_hi_ber(hi_ber), .i_pcs_ber_counter(ber_counter),
        .i_pcs_ber_common(ber_common), .i_pcs_decoder_err(decoder_err),
        .i_pcs_pattern_err(pattern_err), .i_pcs_lane_ids(lane_ids),
        .o_gpio(o_gpio), .o_soft_reset(o_soft_reset), .o_loopback(o_loopback),
        .o_tx_test_pattern(o_tx_test_pattern), .o_rx_test_pattern(o_rx_test_pattern),
        .o_enable_modules(o_enable_modules),
        .o_blksync_invalid_sh_limit(o_blksync_invalid_sh_limit),
        .o_blksync_locked_window(o_blksync_locked_window),
        .o_blksync_unlocked_window(o_blksync_unlocked_window),
        .o_align_invalid_thr(o_align_invalid_thr), .o_align_valid_thr(o_align_valid_thr),
        .o_align_mask(o_align_mask), .o_channel_select(o_channel_select),
        .o_channel_update(o_channel_update), .o_channel_start_break(o_channel_start_break),
        .o_channel_mode(o_channel_mode), .o_channel_burst(o_channel_burst),
        .o_channel_period(o_channel_period), .o_channel_repeat(o_channel_repeat),
        .o_channel_skew(o_channel_skew)
);

function automatic logic [31:0] xorshift32();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
endfunction

// expected readback, lane 0 in the top slice of the buses
function automatic logic [31:0] format_read(input logic [6:0] op);
        logic [31:0] w;
        int lane;
        w = '0;
        if (op == `RF_OP_STATUS)
                w[3:0] = {&block_lock, &lane_aligned, all_deskew, all_reorder};
        else if (op == `RF_OP_HI_BER)
                w[19:0] = hi_ber;
        else if (op == `RF_OP_BLOCK_LOCK)
                w[19:0] = block_lock;
        else if (op == `RF_OP_ALIGN_LOCK)
                w[19:0] = lane_aligned;
        else if (op >= `RF_OP_BERCNT_LANE0 && op < `RF_OP_BER_COMMON)
        begin
                lane = op - `RF_OP_BERCNT_LANE0;
                w[19:0] = ber_counter[(19 - lane)*20 +: 20];
        end
        else if (op == `RF_OP_BER_COMMON)
                w[26:0] = ber_common;
        else if (op == `RF_OP_ERR_BLOCKS)
                w = decoder_err;
        else if (op == `RF_OP_PATTERN_ERR)
                w[15:0] = pattern_err;
        else
        begin
                for (int j = 0; j < 4; j++)
                begin
                        lane = 4*(op - `RF_OP_LANE_MAP_A) + j;
                        w[31 - 8*j -: 8] = {3'b000, lane_ids[(19 - lane)*5 +: 5]};
                end
        end
        return w;
endfunction

task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] act,
                       input bit is_gpio);
        if (exp !== act)
        begin
                $display("ERROR %s expected %h got %h at %0t", name, exp, act, $time);
                if (is_gpio)
                        err_gpio++;
                else
                        err_cfg++;
        end
endtask

task automatic check_outputs();
        logic [71:0] mask_exp;
        mask_exp = {cfg[10], cfg[9], cfg[8]};
        compare("o_soft_reset", cfg[1][0], o_soft_reset, 0);
        compare("o_loopback", cfg[1][1], o_loopback, 0);
        compare("o_tx_test_pattern", cfg[1][2], o_tx_test_pattern, 0);
        compare("o_rx_test_pattern", cfg[1][3], o_rx_test_pattern, 0);
        compare("o_enable_modules", cfg[2], o_enable_modules, 0);
        compare("o_blksync_invalid_sh_limit", cfg[3][19:0], o_blksync_invalid_sh_limit, 0);
        compare("o_blksync_locked_window", cfg[4][19:0], o_blksync_locked_window, 0);
        compare("o_blksync_unlocked_window", cfg[5][19:0], o_blksync_unlocked_window, 0);
        compare("o_align_invalid_thr", cfg[6][19:0], o_align_invalid_thr, 0);
        compare("o_align_valid_thr", cfg[7][19:0], o_align_valid_thr, 0);
        compare("o_align_mask", mask_exp[65:0], o_align_mask, 0);
        compare("o_channel_update", cfg[11][3:0], o_channel_update, 0);
        compare("o_channel_start_break", cfg[12][19:0], o_channel_start_break, 0);
        compare("o_channel_mode", cfg[14][3:0], o_channel_mode, 0);
        compare("o_channel_burst", cfg[15][21:0], o_channel_burst, 0);
        compare("o_channel_period", cfg[16][21:0], o_channel_period, 0);
        compare("o_channel_repeat", cfg[17][21:0], o_channel_repeat, 0);
        compare("o_channel_select", cfg[18][19:0], o_channel_select, 0);
        compare("o_channel_skew", cfg[19][4:0], o_channel_skew, 0);
        compare("o_gpio", exp_gpio, o_gpio, 1);
endtask

task automatic randomize_pcs();
        block_lock = xorshift32();
        if (xorshift32() % 3 == 0)
                block_lock = '1;        // let the AND in the status word go high
        lane_aligned = xorshift32();
        if (xorshift32() % 3 == 0)
                lane_aligned = '1;
        hi_ber      = xorshift32();
        {all_deskew, all_reorder} = xorshift32();
        ber_common  = xorshift32();
        decoder_err = xorshift32();
        pattern_err = xorshift32();
        for (int l = 0; l < 20; l++)
        begin
                ber_counter[l*20 +: 20] = xorshift32();
                lane_ids[l*5 +: 5]      = xorshift32();
        end
endtask

// drive one gpio word, update the model, check one cycle later
task automatic apply(input logic [6:0] op, input logic en, input logic [23:0] data);
        i_gpio = {op, en, data};
        if (en && op >= 1 && op <= 19)
                cfg[op] = data;
        else if (en && op >= `RF_OP_STATUS && op <= `RF_OP_LANE_MAP_A + 4)
                exp_gpio = format_read(op);
        @(posedge clock);
        #5;
        check_outputs();
endtask

initial
begin
        while (cycles < CYCLE_LIMIT)
                @(posedge clock) cycles++;
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
end

initial
begin
        logic [31:0] r;
        logic [6:0]  op;
        seed = 32'h788d7a59;
        cycles = 0;
        err_cfg = 0;
        err_gpio = 0;
        exp_gpio = '0;
        for (int k = 1; k <= 19; k++)
                cfg[k] = '0;
        i_gpio = '0;
        {block_lock, lane_aligned, hi_ber, all_deskew, all_reorder} = '0;
        {ber_counter, ber_common, decoder_err, pattern_err, lane_ids} = '0;

        @(negedge reset);
        check_outputs();        // everything cleared by reset

        for (int i = 0; i < N_WRITES; i++)
                apply(1 + xorshift32() % 19, 1'b1, xorshift32());

        apply(`RF_OP_ALIGN_MASK_LOW, 1'b1, xorshift32());
        apply(`RF_OP_ALIGN_MASK_MID, 1'b1, xorshift32());
        apply(`RF_OP_ALIGN_MASK_HIGH, 1'b1, xorshift32());

        for (int i = 0; i < N_READS; i++)
        begin
                randomize_pcs();
                apply(`RF_OP_STATUS + xorshift32() % 32, 1'b1, xorshift32());
        end

        // idle, undefined, write and read cycles mixed
        for (int i = 0; i < N_MIXED; i++)
        begin
                randomize_pcs();
                r = xorshift32();
                case (r[1:0])
                        2'd0: op = xorshift32();
                        2'd1: op = (r[3:2] == 0) ? 7'd0 :
                                   (r[2] ? 7'd20 + r[15:8] % 20 : 7'd72 + r[15:8] % 56);
                        2'd2: op = 1 + r[15:8] % 19;
                        default: op = `RF_OP_STATUS + r[15:8] % 32;
                endcase
                apply(op, r[1:0] != 2'd0, xorshift32());
        end

        $display("errors: config %0d gpio %0d", err_cfg, err_gpio);
        if (err_cfg + err_gpio == 0)
                $display("*** PASSED ***");
        else
                $display("*** FAILED ***");
        $finish;
end

endmodule
